//--- scope_capture.f
common/scope_pkg.sv
common/dma_pkg.sv
verilog/timebase_gen.sv
data_gen/scope_data_gen.sv
dma/stream_fifo.sv
dma/dma_writer.sv
verilog/scope_top.sv
test/scope_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the scope_capture simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module scope_tb -f scope_capture.f -o scope_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/scope_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
else
    exit 1
fi

//--- test/scope_tb.sv
`timescale 1ns/1ps

module scope_tb;

    localparam int lw = scope_pkg::length_width;
    localparam int aw = dma_pkg::addr_width;
    localparam int enable_frames = 10;
    localparam int clean_frames = 4;
    localparam int watchdog_cycles = 12 * 64 * (6 + 4) + 12 * scope_pkg::backoff_delay;

    logic          clock;
    logic          reset;
    logic          enable;
    logic          trigger;
    logic [15:0]   period;
    logic [lw-1:0] packet_length;
    logic          stall;
    logic [aw-1:0] read_addr;
    logic [31:0]   read_data;
    logic          dma_done;
    logic [15:0]   frame_count;

    int          errors;
    int          checks;
    int          done_pulses;
    int          cur_len;
    int          cur_period;
    int          base_pulses;
    bit          stall_on;
    bit          monitor_on;
    logic        done_q;
    logic [15:0] count_q;

    scope_top dut_i (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .period        (period),
        .packet_length (packet_length),
        .stall         (stall),
        .read_addr     (read_addr),
        .read_data     (read_data),
        .dma_done      (dma_done),
        .frame_count   (frame_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Buffer word at addr for a frame of len samples per channel, channel-major
    function automatic logic [31:0] expected_word(input int addr, input int len);
        int ch;
        int idx;
        ch = addr / len;
        idx = addr % len;
        return scope_pkg::output_bias + 32'(idx) + scope_pkg::channel_step * 32'(ch);
    endfunction

    // Bus stall with a 30% chance per cycle once enabled
    always @(posedge clock) begin
        if (stall_on) begin
            stall <= ($urandom_range(99) < 30);
        end else begin
            stall <= 1'b0;
        end
    end

    // dma_done must be a single-cycle pulse and frame_count must step with it
    always @(negedge clock) begin
        if (monitor_on) begin
            if (dma_done) begin
                done_pulses++;
                checks += 2;
                assert (!done_q) else begin
                    errors++;
                    $display("Fail at time %0t: dma_done high for more than one cycle", $time);
                end
                assert (frame_count == count_q + 16'd1) else begin
                    errors++;
                    $display("Fail at time %0t: frame_count %0d on dma_done, expected %0d",
                             $time, frame_count, count_q + 16'd1);
                end
            end else begin
                checks++;
                assert (frame_count == count_q) else begin
                    errors++;
                    $display("Fail at time %0t: frame_count changed to %0d without dma_done",
                             $time, frame_count);
                end
            end
        end
        done_q = dma_done;
        count_q = frame_count;
    end

    task automatic choose_setup();
        cur_len = $urandom_range(scope_pkg::max_packet_length, 1);
        cur_period = $urandom_range(6, 2);
        @(posedge clock);
        packet_length <= cur_len[lw-1:0];
        period <= cur_period[15:0];
    endtask

    task automatic wait_done();
        do begin
            @(negedge clock);
        end while (!dma_done);
    endtask

    // Pipelined readback, each word is checked one cycle after its address
    task automatic read_frame(input int len);
        int words;
        logic [31:0] want;
        words = scope_pkg::n_dest * len;
        for (int i = 0; i <= words; i++) begin
            @(posedge clock);
            if (i < words) begin
                read_addr <= i[aw-1:0];
            end
            @(negedge clock);
            if (i > 0) begin
                want = expected_word(i - 1, len);
                checks++;
                assert (read_data == want) else begin
                    errors++;
                    $display("Fail at time %0t: word %0d is %0d, expected %0d",
                             $time, i - 1, read_data, want);
                end
            end
        end
    endtask

    initial begin
        reset = 1'b0;
        enable = 1'b0;
        trigger = 1'b0;
        period = 16'd4;
        packet_length = lw'(4);
        stall = 1'b0;
        read_addr = '0;
        errors = 0;
        checks = 0;
        done_pulses = 0;
        stall_on = 1'b0;
        monitor_on = 1'b0;
        done_q = 1'b0;
        count_q = '0;
        void'($urandom(87));

        repeat (10) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        monitor_on = 1'b1;
        checks += 2;
        assert (!dma_done && frame_count == 16'd0) else begin
            errors++;
            $display("Fail at time %0t: dma_done %0b frame_count %0d after reset",
                     $time, dma_done, frame_count);
        end

        // No start source, so no frame may complete
        repeat (200) @(posedge clock);
        checks++;
        assert (done_pulses == 0) else begin
            errors++;
            $display("A frame completed while enable and trigger were low");
        end

        // Free-running frames, the later ones under random stall
        choose_setup();
        enable <= 1'b1;
        for (int f = 0; f < enable_frames; f++) begin
            wait_done();
            if (f == clean_frames - 1) begin
                stall_on = 1'b1;
            end
            read_frame(cur_len);
            if (f < enable_frames - 1) begin
                choose_setup();
            end else begin
                @(posedge clock);
                enable <= 1'b0;
            end
        end

        // Let the last backoff finish, then start one frame from a trigger edge
        repeat (scope_pkg::backoff_delay) @(posedge clock);
        choose_setup();
        trigger <= 1'b1;
        repeat (5) @(posedge clock);
        trigger <= 1'b0;
        wait_done();
        read_frame(cur_len);
        @(posedge clock);
        base_pulses = done_pulses;
        repeat (scope_pkg::backoff_delay + 64 * cur_period) @(posedge clock);
        checks++;
        assert (done_pulses == base_pulses) else begin
            errors++;
            $display("A single trigger edge produced more than one frame");
        end

        @(negedge clock);
        checks++;
        assert (frame_count == 16'(enable_frames + 1)) else begin
            errors++;
            $display("Fail at time %0t: frame_count %0d at the end, expected %0d",
                     $time, frame_count, enable_frames + 1);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the frames did not complete in time",
                 watchdog_cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- verilog/scope_top.sv
`timescale 1ns/1ps

module scope_top (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               enable,
    input  logic                               trigger,
    input  logic [15:0]                        period,
    input  logic [scope_pkg::length_width-1:0] packet_length,
    input  logic                               stall,
    input  logic [dma_pkg::addr_width-1:0]     read_addr,
    output logic [31:0]                        read_data,
    output logic                               dma_done,
    output logic [15:0]                        frame_count
);

    logic           tb_run;
    logic           tick;
    logic           gen_valid;
    logic           gen_ready;
    logic [31:0]    gen_data;
    logic [7:0]     gen_dest;
    logic           gen_last;
    dma_pkg::beat_t gen_beat;
    logic           fifo_valid;
    logic           fifo_ready;
    dma_pkg::beat_t fifo_beat;

    timebase_gen timebase_i (
        .clock  (clock),
        .reset  (reset),
        .run    (tb_run),
        .period (period),
        .tick   (tick)
    );

    scope_data_gen data_gen_i (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .packet_length (packet_length),
        .tick          (tick),
        .dma_done      (dma_done),
        .tb_run        (tb_run),
        .valid         (gen_valid),
        .ready         (gen_ready),
        .data          (gen_data),
        .dest          (gen_dest),
        .last          (gen_last)
    );

    // Generator fields are packed into one beat for the FIFO
    assign gen_beat.data = gen_data;
    assign gen_beat.dest = gen_dest;
    assign gen_beat.last = gen_last;

    stream_fifo #(
        .payload_t (dma_pkg::beat_t),
        .depth     (dma_pkg::fifo_depth)
    ) fifo_i (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (gen_valid),
        .in_ready    (gen_ready),
        .in_payload  (gen_beat),
        .out_valid   (fifo_valid),
        .out_ready   (fifo_ready),
        .out_payload (fifo_beat)
    );

    dma_writer writer_i (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .valid       (fifo_valid),
        .ready       (fifo_ready),
        .beat        (fifo_beat),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .dma_done    (dma_done),
        .frame_count (frame_count)
    );

endmodule

//--- dma/dma_writer.sv
`timescale 1ns/1ps

module dma_writer (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           stall,
    input  logic                           valid,
    output logic                           ready,
    input  dma_pkg::beat_t                 beat,
    input  logic [dma_pkg::addr_width-1:0] read_addr,
    output logic [31:0]                    read_data,
    output logic                           dma_done,
    output logic [15:0]                    frame_count
);

    localparam int aw = dma_pkg::addr_width;
    localparam logic [aw-1:0] last_addr = aw'(dma_pkg::buffer_depth - 1);

    logic [31:0]   buffer [dma_pkg::buffer_depth];
    logic [aw-1:0] wr_addr;
    logic          wr_en;
    logic          frame_written;

    // The bus accepts a word on every cycle it is not stalled
    assign ready = !stall;
    assign wr_en = valid && ready;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            buffer[wr_addr] <= beat.data;
        end
        read_data <= buffer[read_addr];
    end

    // Completion is reported one edge after the last word lands
    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_addr       <= '0;
            frame_written <= 1'b0;
            dma_done      <= 1'b0;
            frame_count   <= '0;
        end else begin
            frame_written <= wr_en && beat.last;
            dma_done      <= frame_written;
            if (frame_written) begin
                wr_addr     <= '0;
                frame_count <= frame_count + 1'b1;
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // The frame must end on or before the final buffer word
    a_addr_in_range: assert property (@(posedge clock) disable iff (!reset)
        wr_en && wr_addr == last_addr |-> beat.last);

    // Every frame starts with the first channel at address 0
    a_frame_start: assert property (@(posedge clock) disable iff (!reset)
        wr_en && wr_addr == '0 |-> beat.dest == scope_pkg::dest_start);

endmodule

//--- dma/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = dma_pkg::beat_t,
    parameter int  depth     = dma_pkg::fifo_depth
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    localparam int ptr_width = depth > 1 ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);
    localparam logic [ptr_width-1:0] last_ptr = ptr_width'(depth - 1);
    localparam logic [count_width-1:0] full_count = count_width'(depth);

    payload_t               mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic [count_width-1:0] ptr_gap;
    logic                   push;
    logic                   pop;

    assign in_ready    = count != full_count;
    assign out_valid   = count != '0;
    assign out_payload = mem[rd_ptr];
    assign push        = in_valid && in_ready;
    assign pop         = out_valid && out_ready;

    // Occupancy as seen from the pointers when they differ
    assign ptr_gap = wr_ptr >= rd_ptr ? count_width'(wr_ptr - rd_ptr)
                                      : count_width'(depth + int'(wr_ptr) - int'(rd_ptr));

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_payload;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr == last_ptr ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr == last_ptr ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // A write into a full FIFO would lift the count above depth
    a_no_write_full: assert property (@(posedge clock) disable iff (!reset)
        count <= full_count);

    // A read from an empty FIFO would leave the pointers out of step with the count
    a_no_read_empty: assert property (@(posedge clock) disable iff (!reset)
        wr_ptr != rd_ptr |-> count == ptr_gap);

endmodule

//--- data_gen/scope_data_gen.sv
`timescale 1ns/1ps

module scope_data_gen (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               enable,
    input  logic                               trigger,
    input  logic [scope_pkg::length_width-1:0] packet_length,
    input  logic                               tick,
    input  logic                               dma_done,
    output logic                               tb_run,
    output logic                               valid,
    input  logic                               ready,
    output logic [31:0]                        data,
    output logic [7:0]                         dest,
    output logic                               last
);

    localparam logic [7:0] dest_last = scope_pkg::dest_start + 8'(scope_pkg::n_dest - 1);

    typedef enum logic [2:0] {
        idle,
        wait_tb,
        emit,
        wait_dma_done,
        backoff
    } state_t;

    state_t                               state;
    logic                                 trigger_q;
    logic                                 start;
    logic [scope_pkg::length_width-1:0]   len_q;
    logic [scope_pkg::length_width-1:0]   index;
    logic [7:0]                           chan;
    logic [scope_pkg::backoff_width-1:0]  backoff_cnt;
    logic                                 chan_end;
    logic                                 frame_end;
    logic [31:0]                          sample;

    // Free-running copy of trigger for edge detection
    always_ff @(posedge clock) begin
        trigger_q <= trigger;
    end

    assign start     = enable || (trigger && !trigger_q);
    assign chan_end  = index == len_q - 1'b1;
    assign frame_end = chan_end && chan == dest_last;
    assign sample    = scope_pkg::output_bias + 32'(index)
                     + scope_pkg::channel_step * 32'(chan - scope_pkg::dest_start);

    // The timebase only runs while a frame is being produced
    assign tb_run = state == wait_tb || state == emit;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= idle;
            valid       <= 1'b0;
            index       <= '0;
            chan        <= scope_pkg::dest_start;
            len_q       <= '0;
            backoff_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    index <= '0;
                    chan  <= scope_pkg::dest_start;
                    if (start) begin
                        len_q <= packet_length;
                        state <= wait_tb;
                    end
                end
                wait_tb: begin
                    if (tick) begin
                        data  <= sample;
                        dest  <= chan;
                        last  <= frame_end;
                        valid <= 1'b1;
                        if (chan_end) begin
                            index <= '0;
                            chan  <= chan + 1'b1;
                        end else begin
                            index <= index + 1'b1;
                        end
                        state <= emit;
                    end
                end
                emit: begin
                    // Ticks seen here are dropped, the next sample waits for a later one
                    if (ready) begin
                        valid <= 1'b0;
                        state <= last ? wait_dma_done : wait_tb;
                    end
                end
                wait_dma_done: begin
                    if (dma_done) begin
                        backoff_cnt <= '0;
                        state       <= backoff;
                    end
                end
                backoff: begin
                    if (int'(backoff_cnt) == scope_pkg::backoff_delay - 1) begin
                        state <= idle;
                    end else begin
                        backoff_cnt <= backoff_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // A pending beat must not change until the FIFO takes it
    a_hold_beat: assert property (@(posedge clock) disable iff (!reset)
        valid && !ready |=> valid && $stable(data) && $stable(dest) && $stable(last));

    a_length_range: assert property (@(posedge clock) disable iff (!reset)
        state == idle && start |->
            packet_length != '0 && int'(packet_length) <= scope_pkg::max_packet_length);

endmodule

//--- verilog/timebase_gen.sv
`timescale 1ns/1ps

module timebase_gen (
    input  logic        clock,
    input  logic        reset,
    input  logic        run,
    input  logic [15:0] period,
    output logic        tick
);

    logic        run_q;
    logic [15:0] count;

    // Counter reloads on the rising edge of run and whenever it hits 1
    always_ff @(posedge clock) begin
        if (!reset) begin
            run_q <= 1'b0;
            count <= '0;
        end else begin
            run_q <= run;
            if (!run) begin
                count <= '0;
            end else if (!run_q || count == 16'd1) begin
                count <= period;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign tick = run && run_q && count == 16'd1;

    // A period below 2 would leave no gap between consecutive ticks
    a_period_min: assert property (@(posedge clock) disable iff (!reset)
        run |-> period >= 16'd2);

endmodule

//--- common/dma_pkg.sv
package dma_pkg;

    // One full frame fits exactly in the buffer
    localparam int buffer_depth = scope_pkg::n_dest * scope_pkg::max_packet_length;
    localparam int addr_width = 6;

    localparam int fifo_depth = 4;

    // A single stream beat between generator, FIFO and writer
    typedef struct packed {
        logic [31:0] data;
        logic [7:0]  dest;
        logic        last;
    } beat_t;

endpackage

//--- common/scope_pkg.sv
package scope_pkg;

    // Channel numbers used as stream destinations
    localparam logic [7:0] dest_start = 8'd1;
    localparam int n_dest = 4;

    // Sample value = output_bias + index + channel_step * (dest - dest_start)
    localparam logic [31:0] channel_step = 32'd2000;
    localparam logic [31:0] output_bias = 32'd100;

    // Idle cycles after dma_done before the generator may start again
    localparam int backoff_delay = 128;

    // Wide enough to count up to backoff_delay - 1
    localparam int backoff_width = 8;

    // Samples per channel, packet_length ranges from 1 to this value
    localparam int max_packet_length = 16;
    localparam int length_width = 5;

endpackage
